// File: Makefile
# Verilator flow for the snake game core

TOP = snakeGame_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "RESULT: PASS" sim.log && ! grep -q "RESULT: FAIL" sim.log

lint:
	verilator --lint-only --timing -Wall +incdir+. snakePkg.sv steerControl.sv \
		bodySegment.sv frameRenderer.sv snakeGame.sv --top-module snakeGame

clean:
	rm -rf obj_dir sim.log

// File: bodySegment.sv
/*
 * one snake cell with its position register,
 * shift load on step and compare against the next head
 */
`timescale 1ns/1ps
`include "snakeGame_cfg.svh"

module bodySegment
(
    input  logic           Clock,
    input  logic           reset,
    input  logic           step,
    input  snakePkg::gridX startX,
    input  snakePkg::gridY startY,
    input  snakePkg::gridX loadX,
    input  snakePkg::gridY loadY,
    input  snakePkg::gridX nextX,
    input  snakePkg::gridY nextY,
    output snakePkg::gridX segX,
    output snakePkg::gridY segY,
    output logic           hitHere
);

    // start cell on reset, predecessor (or next head) on step
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            segX <= startX;
            segY <= startY;
        end
        else if (step)
        begin
            segX <= loadX;
            segY <= loadY;
        end
    end

    // head would land on this cell
    assign hitHere = (segX == nextX) && (segY == nextY);

    // wrap logic upstream keeps rows on the board
    rowOnBoard: assert property (@(posedge Clock) disable iff (reset)
        segY < snakePkg::gridY'(`SNAKE_GRID_H));

endmodule

// File: frameRenderer.sv
/*
 * game sequencer, free step timer and
 * valid/ready pixel stream for the draw and erase frames
 */
`timescale 1ns/1ps
`include "snakeGame_cfg.svh"

module frameRenderer
(
    input  logic            Clock,
    input  logic            reset,
    input  logic            start,
    input  logic            hit,
    input  logic            pixReady,
    input  snakePkg::gridX  segX [`SNAKE_LEN],
    input  snakePkg::gridY  segY [`SNAKE_LEN],
    output logic            step,
    output logic            pixValid,
    output logic            gameOver,
    output snakePkg::pixelX pixX,
    output snakePkg::pixelY pixY,
    output snakePkg::colour pixColour
);

    localparam int SEG_W = $clog2(`SNAKE_LEN);
    localparam int TIMER_W = $clog2(`SNAKE_STEP_CYCLES);
    localparam logic [3:0] LAST_OFFSET = 4'(`SNAKE_BLOCK - 1);

    enum logic [2:0] {
        stIdle,
        stDraw,
        stWaitTick,
        stErase,
        stHitCheck,
        stMove,
        stOver
    } state, nextState;

    logic [SEG_W-1:0]   segIdx;
    logic [3:0]         rowOff;
    logic [3:0]         colOff;
    logic [TIMER_W-1:0] stepTimer;
    logic               tick;
    logic               tickPending;
    logic               accept;
    logic               lastCol;
    logic               lastRow;
    logic               lastSeg;
    logic               lastPixel;

    assign accept = pixValid && pixReady;
    assign lastCol = (colOff == LAST_OFFSET);
    assign lastRow = (rowOff == LAST_OFFSET);
    assign lastSeg = (segIdx == SEG_W'(`SNAKE_LEN - 1));
    assign lastPixel = accept && lastCol && lastRow && lastSeg;

    // step timer runs freely and is never stopped by the frames
    assign tick = (stepTimer == TIMER_W'(`SNAKE_STEP_CYCLES - 1));

    always_ff @(posedge Clock)
    begin
        if (reset || tick)
            stepTimer <= '0;
        else
            stepTimer <= stepTimer + 1'b1;
    end

    // remember a tick that fell inside a frame
    always_ff @(posedge Clock)
    begin
        if (reset)
            tickPending <= 1'b0;
        else if (state == stWaitTick)
            tickPending <= 1'b0;
        else if (tick)
            tickPending <= 1'b1;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            stIdle:     if (start) nextState = stDraw;
            stDraw:     if (lastPixel) nextState = stWaitTick;
            stWaitTick: if (tick || tickPending) nextState = stErase;
            stErase:    if (lastPixel) nextState = stHitCheck;
            stHitCheck: nextState = hit ? stOver : stMove;
            stMove:     nextState = stDraw;
            stOver:     nextState = stOver;
            default:    nextState = stIdle;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            state <= stIdle;
        else
            state <= nextState;
    end

    // column inner, row outer, then segment
    // all three wrap to zero at the end of a frame
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            segIdx <= '0;
            rowOff <= '0;
            colOff <= '0;
        end
        else if (accept)
        begin
            if (!lastCol)
                colOff <= colOff + 4'd1;
            else
            begin
                colOff <= '0;
                if (!lastRow)
                    rowOff <= rowOff + 4'd1;
                else
                begin
                    rowOff <= '0;
                    segIdx <= lastSeg ? '0 : segIdx + 1'b1;
                end
            end
        end
    end

    assign pixValid = (state == stDraw) || (state == stErase);
    assign step = (state == stMove);
    assign gameOver = (state == stOver);

    // block origin scaled to pixels plus offsets
    // counters and cells hold while a pixel waits
    assign pixX = snakePkg::pixelX'(segX[segIdx]) * snakePkg::pixelX'(`SNAKE_BLOCK)
                + snakePkg::pixelX'(colOff);
    assign pixY = snakePkg::pixelY'(segY[segIdx]) * snakePkg::pixelY'(`SNAKE_BLOCK)
                + snakePkg::pixelY'(rowOff);
    assign pixColour = (state == stErase) ? snakePkg::colour'(`SNAKE_BACKGROUND)
                                          : snakePkg::colour'(`SNAKE_COLOUR);

    pixelHold: assert property (@(posedge Clock) disable iff (reset)
        pixValid && !pixReady |=> pixValid && $stable(pixX) && $stable(pixY)
                                  && $stable(pixColour));

    // cells move only with every counter back at the first pixel
    stepOutsideFrame: assert property (@(posedge Clock) disable iff (reset)
        step |-> (segIdx == '0) && (rowOff == '0) && (colOff == '0));

endmodule

// File: sim.f
+incdir+.
snakePkg.sv
steerControl.sv
bodySegment.sv
frameRenderer.sv
snakeGame.sv
snakeGame_tb.sv

// File: snakeGame.sv
/*
 * top level with steering, the segment
 * chain and the renderer, plus the body hit reduction
 */
`timescale 1ns/1ps
`include "snakeGame_cfg.svh"

module snakeGame
(
    input  logic            Clock,
    input  logic            reset,
    input  logic            start,
    input  logic            keyRight,
    input  logic            keyDown,
    input  logic            keyUp,
    input  logic            keyLeft,
    output logic            pixValid,
    input  logic            pixReady,
    output snakePkg::pixelX pixX,
    output snakePkg::pixelY pixY,
    output snakePkg::colour pixColour,
    output logic            gameOver
);

    logic                 step;
    logic                 hit;
    snakePkg::gridX       nextX;
    snakePkg::gridY       nextY;
    snakePkg::gridX       segX [`SNAKE_LEN];
    snakePkg::gridY       segY [`SNAKE_LEN];
    snakePkg::gridX       loadX [`SNAKE_LEN];
    snakePkg::gridY       loadY [`SNAKE_LEN];
    logic [`SNAKE_LEN-1:0] hitHere;

    steerControl steer
    (
        .Clock    (Clock),
        .reset    (reset),
        .step     (step),
        .keyRight (keyRight),
        .keyDown  (keyDown),
        .keyUp    (keyUp),
        .keyLeft  (keyLeft),
        .headX    (segX[0]),
        .headY    (segY[0]),
        .nextX    (nextX),
        .nextY    (nextY)
    );

    for (genvar i = 0; i < `SNAKE_LEN; i++)
    begin : gSegment
        // head takes the next cell, body follows its predecessor
        if (i == 0)
        begin : gHead
            assign loadX[i] = nextX;
            assign loadY[i] = nextY;
        end
        else
        begin : gBody
            assign loadX[i] = segX[i-1];
            assign loadY[i] = segY[i-1];
        end

        bodySegment segment
        (
            .Clock   (Clock),
            .reset   (reset),
            .step    (step),
            .startX  (snakePkg::gridX'(`SNAKE_START_X - i)),
            .startY  (snakePkg::gridY'(`SNAKE_START_Y)),
            .loadX   (loadX[i]),
            .loadY   (loadY[i]),
            .nextX   (nextX),
            .nextY   (nextY),
            .segX    (segX[i]),
            .segY    (segY[i]),
            .hitHere (hitHere[i])
        );
    end

    // tail leaves its cell on the same step, so it cannot be hit
    assign hit = |hitHere[`SNAKE_LEN-2:0];

    frameRenderer renderer
    (
        .Clock     (Clock),
        .reset     (reset),
        .start     (start),
        .hit       (hit),
        .pixReady  (pixReady),
        .segX      (segX),
        .segY      (segY),
        .step      (step),
        .pixValid  (pixValid),
        .gameOver  (gameOver),
        .pixX      (pixX),
        .pixY      (pixY),
        .pixColour (pixColour)
    );

endmodule

// File: snakeGame_cfg.svh
/*
 * board geometry, snake length and start cell,
 * draw and erase colours, step timer period
 */
`ifndef SNAKE_GAME_CFG_SVH
`define SNAKE_GAME_CFG_SVH

// board size in blocks
`define SNAKE_GRID_W 16
`define SNAKE_GRID_H 12
// block edge in pixels
`define SNAKE_BLOCK 10
// fixed number of segments
`define SNAKE_LEN 6
// head cell after reset with the body trailing to the left
`define SNAKE_START_X 8
`define SNAKE_START_Y 6
// rgb colours
`define SNAKE_COLOUR 3'b010
`define SNAKE_BACKGROUND 3'b000
// clocks between game steps
`define SNAKE_STEP_CYCLES 1500

`endif

// File: snakeGame_tb.sv
/*
 * testbench for snakeGame with clock, reset, random keys and back-pressure,
 * reference model of the snake, compare tasks and watchdog
 */
`timescale 1ns/1ps
`include "snakeGame_cfg.svh"

module snakeGame_tb;

    localparam int BLOCK_PIXELS = `SNAKE_BLOCK * `SNAKE_BLOCK;
    localparam int FRAME_PIXELS = `SNAKE_LEN * BLOCK_PIXELS;
    localparam int STEPS_PLANNED = 34;
    localparam int FRAMES_PLANNED = 2 * STEPS_PLANNED + 1;
    localparam int TIMEOUT_CYCLES = FRAMES_PLANNED * FRAME_PIXELS * 4
                                  + STEPS_PLANNED * `SNAKE_STEP_CYCLES * 2;

    logic            Clock;
    logic            reset;
    logic            start;
    logic            keyRight;
    logic            keyDown;
    logic            keyUp;
    logic            keyLeft;
    logic            pixValid;
    logic            pixReady;
    snakePkg::pixelX pixX;
    snakePkg::pixelY pixY;
    snakePkg::colour pixColour;
    logic            gameOver;

    // model state is six cells, head first, and the steering direction
    int                 cellX [`SNAKE_LEN];
    int                 cellY [`SNAKE_LEN];
    snakePkg::direction modelDir;
    snakePkg::direction turnBase;
    snakePkg::pixelX    expX [FRAME_PIXELS];
    snakePkg::pixelY    expY [FRAME_PIXELS];

    int pixelErrors;
    int overErrors;
    int otherErrors;
    int pixelsChecked;

    snakeGame dut
    (
        .Clock     (Clock),
        .reset     (reset),
        .start     (start),
        .keyRight  (keyRight),
        .keyDown   (keyDown),
        .keyUp     (keyUp),
        .keyLeft   (keyLeft),
        .pixValid  (pixValid),
        .pixReady  (pixReady),
        .pixX      (pixX),
        .pixY      (pixY),
        .pixColour (pixColour),
        .gameOver  (gameOver)
    );

    initial
    begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // sink accepts about 70 percent of cycles
    initial
    begin
        pixReady = 1'b0;
        forever
        begin
            @(posedge Clock);
            pixReady <= (($urandom % 10) < 7);
        end
    end

    function automatic snakePkg::direction reverseOf(input snakePkg::direction d);
        case (d)
            snakePkg::dirRight: return snakePkg::dirLeft;
            snakePkg::dirLeft:  return snakePkg::dirRight;
            snakePkg::dirUp:    return snakePkg::dirDown;
            default:            return snakePkg::dirUp;
        endcase
    endfunction

    // key vector order is right, down, up, left
    function automatic logic [3:0] keyFor(input snakePkg::direction d);
        case (d)
            snakePkg::dirRight: return 4'b1000;
            snakePkg::dirDown:  return 4'b0100;
            snakePkg::dirUp:    return 4'b0010;
            default:            return 4'b0001;
        endcase
    endfunction

    // none, a single key, or two or more at once
    function automatic logic [3:0] randomKeys();
        logic [3:0] keys;
        int         kind;
        kind = int'($urandom % 3);
        keys = 4'b0000;
        if (kind == 1)
            keys = 4'b0001 << ($urandom % 4);
        else if (kind == 2)
            while ($countones(keys) < 2)
                keys = 4'($urandom);
        return keys;
    endfunction

    // straight run over the edge, a reverse press, random play,
    // then a tight turn back into the body
    function automatic logic [3:0] chooseKeys(input int stepIdx);
        snakePkg::direction side;
        side = (turnBase == snakePkg::dirRight || turnBase == snakePkg::dirLeft)
             ? snakePkg::dirDown : snakePkg::dirRight;
        if (stepIdx < 10)
            return 4'b0000;
        else if (stepIdx == 10)
            return keyFor(reverseOf(modelDir));
        else if (stepIdx < STEPS_PLANNED - 4)
            return randomKeys();
        else if (stepIdx == STEPS_PLANNED - 4)
            return keyFor(side);
        else if (stepIdx == STEPS_PLANNED - 3)
            return keyFor(reverseOf(turnBase));
        else if (stepIdx == STEPS_PLANNED - 2)
            return keyFor(reverseOf(side));
        return 4'b0000;
    endfunction

    // move uses the direction held before this step and the keys steer the next one
    function automatic bit modelStep(input logic [3:0] keys);
        int                 nx;
        int                 ny;
        bit                 over;
        snakePkg::direction want;
        nx = cellX[0];
        ny = cellY[0];
        case (modelDir)
            snakePkg::dirRight: nx = (nx + 1) % `SNAKE_GRID_W;
            snakePkg::dirLeft:  nx = (nx + `SNAKE_GRID_W - 1) % `SNAKE_GRID_W;
            snakePkg::dirDown:  ny = (ny + 1) % `SNAKE_GRID_H;
            default:            ny = (ny + `SNAKE_GRID_H - 1) % `SNAKE_GRID_H;
        endcase
        // tail cell is vacated on the same step
        over = 1'b0;
        for (int i = 0; i < `SNAKE_LEN - 1; i++)
            if (cellX[i] == nx && cellY[i] == ny)
                over = 1'b1;
        if (!over)
        begin
            for (int i = `SNAKE_LEN - 1; i > 0; i--)
            begin
                cellX[i] = cellX[i-1];
                cellY[i] = cellY[i-1];
            end
            cellX[0] = nx;
            cellY[0] = ny;
            want = modelDir;
            if (keys[3])
                want = snakePkg::dirRight;
            else if (keys[2])
                want = snakePkg::dirDown;
            else if (keys[1])
                want = snakePkg::dirUp;
            else if (keys[0])
                want = snakePkg::dirLeft;
            if (want != reverseOf(modelDir))
                modelDir = want;
        end
        return over;
    endfunction

    // segment outer, then row, then column
    function automatic void buildFrame();
        int seg;
        int row;
        int col;
        for (int p = 0; p < FRAME_PIXELS; p++)
        begin
            seg = p / BLOCK_PIXELS;
            row = (p % BLOCK_PIXELS) / `SNAKE_BLOCK;
            col = p % `SNAKE_BLOCK;
            expX[p] = snakePkg::pixelX'(cellX[seg] * `SNAKE_BLOCK + col);
            expY[p] = snakePkg::pixelY'(cellY[seg] * `SNAKE_BLOCK + row);
        end
    endfunction

    task automatic checkPixel(input string name,
                              input snakePkg::pixelX wantX, input snakePkg::pixelY wantY,
                              input snakePkg::colour wantC,
                              input snakePkg::pixelX gotX, input snakePkg::pixelY gotY,
                              input snakePkg::colour gotC);
        pixelsChecked++;
        if (gotX !== wantX || gotY !== wantY || gotC !== wantC)
        begin
            pixelErrors++;
            $display("FAILED %s expected x=%0d y=%0d colour=%b actual x=%0d y=%0d colour=%b",
                     name, wantX, wantY, wantC, gotX, gotY, gotC);
        end
    endtask

    task automatic checkGameOver(input string name, input logic want, input logic got);
        if (got !== want)
        begin
            overErrors++;
            $display("FAILED %s gameOver expected %b actual %b", name, want, got);
        end
    endtask

    // entered and left on a falling edge, where valid and ready are settled
    task automatic collectFrame(input string name, input snakePkg::colour wantC,
                                input bit setKeys, input logic [3:0] keys);
        int idx;
        idx = 0;
        while (idx < FRAME_PIXELS)
        begin
            if (pixValid && pixReady)
            begin
                checkPixel($sformatf("%s pixel %0d", name, idx), expX[idx], expY[idx],
                           wantC, pixX, pixY, pixColour);
                idx++;
                // keys move only once the erase frame is under way
                if (setKeys && idx == 1)
                begin
                    @(posedge Clock);
                    {keyRight, keyDown, keyUp, keyLeft} <= keys;
                end
            end
            @(negedge Clock);
        end
    endtask

    initial
    begin
        string      name;
        int         stepIdx;
        int         waited;
        bit         over;
        bit         alive;
        bit         sawPixel;
        bit         dropped;
        logic [3:0] keys;
        void'($urandom(93064));
        reset = 1'b1;
        start = 1'b0;
        {keyRight, keyDown, keyUp, keyLeft} = 4'b0000;
        pixelErrors = 0;
        overErrors = 0;
        otherErrors = 0;
        pixelsChecked = 0;
        turnBase = snakePkg::dirRight;
        repeat (8) @(posedge Clock);
        reset <= 1'b0;

        // renderer idles until start
        for (int c = 0; c < 20; c++)
        begin
            @(negedge Clock);
            if (pixValid)
            begin
                otherErrors++;
                $display("pixValid went high while start was still low");
            end
            checkGameOver("idle after reset", 1'b0, gameOver);
        end
        @(posedge Clock);
        start <= 1'b1;

        for (int i = 0; i < `SNAKE_LEN; i++)
        begin
            cellX[i] = `SNAKE_START_X - i;
            cellY[i] = `SNAKE_START_Y;
        end
        modelDir = snakePkg::dirRight;
        buildFrame();
        @(negedge Clock);
        collectFrame("first draw", snakePkg::colour'(`SNAKE_COLOUR), 1'b0, 4'b0000);

        over = 1'b0;
        alive = 1'b1;
        stepIdx = 0;
        while (alive && stepIdx < STEPS_PLANNED)
        begin
            if (stepIdx == STEPS_PLANNED - 4)
                turnBase = modelDir;
            keys = chooseKeys(stepIdx);
            name = $sformatf("step %0d", stepIdx);
            collectFrame({name, " erase"}, snakePkg::colour'(`SNAKE_BACKGROUND), 1'b1, keys);
            over = modelStep(keys);
            waited = 0;
            while (!pixValid && !gameOver && waited < 8)
            begin
                @(negedge Clock);
                waited++;
            end
            checkGameOver(name, over, gameOver);
            if (gameOver !== over || over)
                alive = 1'b0;
            else if (!pixValid)
            begin
                otherErrors++;
                $display("%s: no draw frame started after the erase frame", name);
                alive = 1'b0;
            end
            else
            begin
                buildFrame();
                collectFrame({name, " draw"}, snakePkg::colour'(`SNAKE_COLOUR), 1'b0, keys);
                stepIdx++;
            end
        end

        if (over && gameOver)
        begin
            sawPixel = 1'b0;
            dropped = 1'b0;
            for (int c = 0; c < 2000; c++)
            begin
                @(negedge Clock);
                if (pixValid)
                    sawPixel = 1'b1;
                if (!gameOver)
                    dropped = 1'b1;
            end
            if (sawPixel)
            begin
                otherErrors++;
                $display("pixels were still offered after the game ended");
            end
            if (dropped)
            begin
                otherErrors++;
                $display("gameOver fell again before reset");
            end
        end
        else if (!over && stepIdx == STEPS_PLANNED)
        begin
            otherErrors++;
            $display("turning the head into the body did not end the game");
        end

        $display("checked %0d pixels: %0d pixel errors, %0d game over errors, %0d other errors",
                 pixelsChecked, pixelErrors, overErrors, otherErrors);
        if (pixelErrors + overErrors + otherErrors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // bound on frames and step waits
    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge Clock);
        $display("watchdog expired after %0d cycles, the run hung", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: snakePkg.sv
/*
 * shared types for block and pixel coordinates,
 * rgb colour and steering direction
 */
package snakePkg;

    // block cell on the board
    typedef logic [3:0] gridX;
    typedef logic [3:0] gridY;

    // screen pixel, 160 columns by 120 rows
    typedef logic [7:0] pixelX;
    typedef logic [6:0] pixelY;

    // one bit per rgb channel
    typedef logic [2:0] colour;

    // opposite directions are bitwise complements
    typedef enum logic [1:0] {
        dirRight = 2'b00,
        dirDown  = 2'b01,
        dirUp    = 2'b10,
        dirLeft  = 2'b11
    } direction;

endpackage

// File: steerControl.sv
/*
 * direction register fed by the keys
 * and the wrapped next-head cell
 */
`timescale 1ns/1ps
`include "snakeGame_cfg.svh"

module steerControl
(
    input  logic           Clock,
    input  logic           reset,
    input  logic           step,
    input  logic           keyRight,
    input  logic           keyDown,
    input  logic           keyUp,
    input  logic           keyLeft,
    input  snakePkg::gridX headX,
    input  snakePkg::gridY headY,
    output snakePkg::gridX nextX,
    output snakePkg::gridY nextY
);

    localparam snakePkg::gridX lastX = snakePkg::gridX'(`SNAKE_GRID_W - 1);
    localparam snakePkg::gridY lastY = snakePkg::gridY'(`SNAKE_GRID_H - 1);

    snakePkg::direction dir;
    snakePkg::direction keyDir;

    // key priority right, down, up, left
    // no key leaves the current direction
    always_comb
    begin
        if (keyRight)
            keyDir = snakePkg::dirRight;
        else if (keyDown)
            keyDir = snakePkg::dirDown;
        else if (keyUp)
            keyDir = snakePkg::dirUp;
        else if (keyLeft)
            keyDir = snakePkg::dirLeft;
        else
            keyDir = dir;
    end

    // a reverse request is the complement of dir and is ignored
    always_ff @(posedge Clock)
    begin
        if (reset)
            dir <= snakePkg::dirRight;
        else if (step && (keyDir != ~dir))
            dir <= keyDir;
    end

    // one block along dir, wrapping at the board edges
    always_comb
    begin
        nextX = headX;
        nextY = headY;
        case (dir)
            snakePkg::dirRight: nextX = (headX == lastX) ? '0 : headX + 4'd1;
            snakePkg::dirLeft:  nextX = (headX == '0) ? lastX : headX - 4'd1;
            snakePkg::dirDown:  nextY = (headY == lastY) ? '0 : headY + 4'd1;
            snakePkg::dirUp:    nextY = (headY == '0) ? lastY : headY - 4'd1;
        endcase
    end

    // the direction never turns straight back in one step
    dirNoReverse: assert property (@(posedge Clock) disable iff (reset)
        dir != ~$past(dir));

endmodule
